/* hdl/fpnc_pkg.sv */
package fpnc_pkg;

  // --------------------------------------------------------------------------
  // Slice geometry
  // --------------------------------------------------------------------------
  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned NUM_LANES   = 2;
  localparam int unsigned TAG_WIDTH   = 4;
  localparam int unsigned LANE_WIDTH  = SLICE_WIDTH / NUM_LANES; // Narrowest lane, FP16

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic {
    SGNJ   = 1'b0,
    MINMAX = 1'b1
  } operation_e;

  // Selects the operation variant in this group
  typedef enum logic [2:0] {
    RNE = 3'b000, // Plain sign injection or min
    RTZ = 3'b001, // Negated sign injection or max
    RDN = 3'b010  // Xor sign injection
  } roundmode_e;

  typedef struct packed {
    logic nv; // Invalid
    logic dz; // Divide by zero
    logic of; // Overflow
    logic uf; // Underflow
    logic nx; // Inexact
  } status_t;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  // Travels with lane 0 to steer the output packing
  typedef struct packed {
    fp_format_e fmt;
    logic       vectorial;
  } aux_t;

  // --------------------------------------------------------------------------
  // Slice and lane records
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic [1:0][SLICE_WIDTH-1:0] operands;
    operation_e                  op;
    roundmode_e                  rnd_mode;
    fp_format_e                  fmt;
    logic                        vectorial;
    tag_t                        tag;
  } slice_req_t;

  typedef struct packed {
    logic [SLICE_WIDTH-1:0] result;
    status_t                status;
    tag_t                   tag;
  } slice_resp_t;

  typedef struct packed {
    logic [1:0][LANE_WIDTH-1:0] operands;
    operation_e                 op;
    roundmode_e                 rnd_mode;
    fp_format_e                 fmt;
  } lane_in_t;

  // Lane 0 also runs FP32, so it sees full-width operands
  typedef struct packed {
    logic [1:0][SLICE_WIDTH-1:0] operands;
    operation_e                  op;
    roundmode_e                  rnd_mode;
    aux_t                        aux;
    tag_t                        tag;
  } lane0_in_t;

  typedef struct packed {
    logic [LANE_WIDTH-1:0] result;
    status_t               status;
  } lane_out_t;

  typedef struct packed {
    logic [SLICE_WIDTH-1:0] result;
    status_t                status;
    aux_t                   aux;
    tag_t                   tag;
  } lane0_out_t;

  // --------------------------------------------------------------------------
  // Width helpers
  // --------------------------------------------------------------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    return (fmt == FP32) ? 32 : 16;
  endfunction

  function automatic int unsigned exp_bits(fp_format_e fmt);
    return (fmt == FP32) ? 8 : 5;
  endfunction

  function automatic int unsigned man_bits(fp_format_e fmt);
    return fp_width(fmt) - exp_bits(fmt) - 1;
  endfunction

endpackage

/* hdl/fpnc_operand_split.sv */
`timescale 1ns/1ps

module fpnc_operand_split (
  input  fpnc_pkg::slice_req_t req_i,
  input  logic                 valid_i,
  // Lane 0, full width with side info
  output fpnc_pkg::lane0_in_t  lane0_o,
  output logic                 lane0_valid_o,
  // Lane 1, upper half only
  output fpnc_pkg::lane_in_t   lane1_o,
  output logic                 lane1_valid_o
);

  localparam int unsigned SW = fpnc_pkg::SLICE_WIDTH;
  localparam int unsigned LW = fpnc_pkg::LANE_WIDTH;

  fpnc_pkg::aux_t aux;

  assign aux.fmt       = req_i.fmt;
  assign aux.vectorial = req_i.vectorial;

  // --------------------------------------------------------------------------
  // Lane 0
  // --------------------------------------------------------------------------
  // Upper bits are ignored inside the lane for FP16
  always_comb begin : split_lane0
    lane0_o.operands = req_i.operands;
    lane0_o.op       = req_i.op;
    lane0_o.rnd_mode = req_i.rnd_mode;
    lane0_o.aux      = aux;
    lane0_o.tag      = req_i.tag;
  end

  assign lane0_valid_o = valid_i;

  // --------------------------------------------------------------------------
  // Lane 1
  // --------------------------------------------------------------------------
  always_comb begin : split_lane1
    for (int i = 0; i < 2; i++) begin
      lane1_o.operands[i] = req_i.operands[i][SW-1:LW]; // Upper half of each operand
    end
    lane1_o.op       = req_i.op;
    lane1_o.rnd_mode = req_i.rnd_mode;
    lane1_o.fmt      = req_i.fmt;
  end

  // Upper lane only serves vector operations
  assign lane1_valid_o = valid_i & req_i.vectorial;

endmodule

/* hdl/fpnc_pipe_reg.sv */
`timescale 1ns/1ps

module fpnc_pipe_reg #(
  parameter int unsigned NumPipeRegs = 2,
  parameter type         PayloadType = logic
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  PayloadType data_i,
  input  logic       valid_i,
  output logic       ready_o,
  output PayloadType data_o,
  output logic       valid_o,
  input  logic       ready_i,
  output logic       busy_o
);

  PayloadType           stage_data [0:NumPipeRegs];
  logic [NumPipeRegs:0] stage_valid;
  logic [NumPipeRegs:0] stage_ready;

  assign stage_data[0]  = data_i;
  assign stage_valid[0] = valid_i;
  assign ready_o        = stage_ready[0];

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic       valid_q;
    PayloadType data_q;

    // Free slot or the next stage drains this cycle
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_valid[i] && stage_ready[i]) begin
        data_q <= stage_data[i]; // Load only on a transfer
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
  end

  assign stage_ready[NumPipeRegs] = ready_i;
  assign data_o                   = stage_data[NumPipeRegs];
  assign valid_o                  = stage_valid[NumPipeRegs];

  if (NumPipeRegs == 0) begin : gen_busy_comb
    assign busy_o = valid_i; // Combinational path
  end else begin : gen_busy_regs
    assign busy_o = |stage_valid[NumPipeRegs:1];
  end

endmodule

/* hdl/fpnc_noncomp_lane.sv */
`timescale 1ns/1ps

module fpnc_noncomp_lane #(
  parameter int unsigned NumPipeRegs = 2,
  parameter type         InType      = fpnc_pkg::lane_in_t,
  parameter type         OutType     = fpnc_pkg::lane_out_t,
  parameter int unsigned LaneWidth   = fpnc_pkg::LANE_WIDTH
) (
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  InType  in_i,
  input  logic   in_valid_i,
  output logic   in_ready_o,
  output OutType out_o,
  output logic   out_valid_o,
  input  logic   out_ready_i,
  output logic   busy_o
);

  // Only the full-width lane carries aux and tag
  localparam bit                   HAS_SIDE_INFO = (LaneWidth == fpnc_pkg::SLICE_WIDTH);
  localparam logic [LaneWidth-1:0] LSB           = 1;

  fpnc_pkg::fp_format_e fmt, fmt_eff;
  logic [LaneWidth-1:0] op_a, op_b;
  logic [LaneWidth-1:0] sign_mask, mag_mask, val_mask, man_mask, exp_mask, quiet_mask;
  logic [LaneWidth-1:0] mag_a, mag_b, val_a, val_b;
  logic                 sign_a, sign_b, nan_a, nan_b, snan_a, snan_b;
  logic                 a_lt_b, pick_a, res_sign;
  logic [LaneWidth-1:0] res;
  fpnc_pkg::status_t    status;
  OutType               lane_res;

  if (HAS_SIDE_INFO) begin : gen_side_info
    assign fmt      = in_i.aux.fmt;
    assign lane_res = '{result: res, status: status, aux: in_i.aux, tag: in_i.tag};
  end else begin : gen_no_side_info
    assign fmt      = in_i.fmt;
    assign lane_res = '{result: res, status: status};
  end

  assign op_a = in_i.operands[0];
  assign op_b = in_i.operands[1];

  // Formats wider than the lane fall back to FP16
  assign fmt_eff = (fpnc_pkg::fp_width(fmt) > LaneWidth) ? fpnc_pkg::FP16 : fmt;

  // --------------------------------------------------------------------------
  // Field decode
  // --------------------------------------------------------------------------
  always_comb begin : decode
    sign_mask  = LSB << (fpnc_pkg::fp_width(fmt_eff) - 1);
    mag_mask   = sign_mask - LSB;
    val_mask   = sign_mask | mag_mask;
    man_mask   = (LSB << fpnc_pkg::man_bits(fmt_eff)) - LSB;
    quiet_mask = LSB << (fpnc_pkg::man_bits(fmt_eff) - 1); // Top mantissa bit
    exp_mask   = mag_mask & ~man_mask;
    sign_a = |(op_a & sign_mask);
    sign_b = |(op_b & sign_mask);
    mag_a  = op_a & mag_mask;
    mag_b  = op_b & mag_mask;
    val_a  = op_a & val_mask; // Operand without bits above the format
    val_b  = op_b & val_mask;
    nan_a  = ((op_a & exp_mask) == exp_mask) && |(op_a & man_mask);
    nan_b  = ((op_b & exp_mask) == exp_mask) && |(op_b & man_mask);
    snan_a = nan_a && !(|(op_a & quiet_mask));
    snan_b = nan_b && !(|(op_b & quiet_mask));
  end

  // Total order on non-NaNs, -0 below +0
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b; // Both negative
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  assign pick_a = (in_i.rnd_mode == fpnc_pkg::RTZ) ? ~a_lt_b : a_lt_b; // max : min

  // --------------------------------------------------------------------------
  // Operation
  // --------------------------------------------------------------------------
  always_comb begin : compute
    res      = '0;
    status   = '0;
    res_sign = sign_b;
    if (in_i.op == fpnc_pkg::SGNJ) begin
      case (in_i.rnd_mode)
        fpnc_pkg::RTZ: res_sign = ~sign_b;
        fpnc_pkg::RDN: res_sign = sign_a ^ sign_b;
        default:       res_sign = sign_b;
      endcase
      res = mag_a | (res_sign ? sign_mask : '0);
    end else begin
      status.nv = snan_a | snan_b;
      if (nan_a && nan_b) begin
        res = exp_mask | quiet_mask; // Canonical NaN
      end else if (nan_a) begin
        res = val_b;
      end else if (nan_b) begin
        res = val_a;
      end else begin
        res = pick_a ? val_a : val_b;
      end
    end
  end

  fpnc_pipe_reg #(
    .NumPipeRegs ( NumPipeRegs ),
    .PayloadType ( OutType     )
  ) i_pipe_reg (
    .clk_i,
    .arst_n_i,
    .data_i  ( lane_res    ),
    .valid_i ( in_valid_i  ),
    .ready_o ( in_ready_o  ),
    .data_o  ( out_o       ),
    .valid_o ( out_valid_o ),
    .ready_i ( out_ready_i ),
    .busy_o
  );

endmodule

/* hdl/fpnc_result_pack.sv */
`timescale 1ns/1ps

module fpnc_result_pack (
  input  fpnc_pkg::lane0_out_t  lane0_i,
  input  logic                  lane0_valid_i,
  input  fpnc_pkg::lane_out_t   lane1_i,
  input  logic                  lane1_valid_i,
  output fpnc_pkg::slice_resp_t resp_o
);

  localparam int unsigned SW   = fpnc_pkg::SLICE_WIDTH;
  localparam int unsigned HALF = fpnc_pkg::LANE_WIDTH;

  logic [SW-1:0]     packed_result;
  fpnc_pkg::status_t lane0_status, lane1_status;
  fpnc_pkg::status_t collapsed_status;

  // --------------------------------------------------------------------------
  // Result packing
  // --------------------------------------------------------------------------
  always_comb begin : pack_result
    packed_result = lane0_i.result; // FP32 comes whole from lane 0
    if (lane0_i.aux.fmt == fpnc_pkg::FP16) begin
      if (lane0_i.aux.vectorial) begin
        packed_result = {lane1_i.result, lane0_i.result[HALF-1:0]};
      end else begin
        // NaN-box the unused upper half
        packed_result = {{HALF{1'b1}}, lane0_i.result[HALF-1:0]};
      end
    end
  end

  // --------------------------------------------------------------------------
  // Status collapse
  // --------------------------------------------------------------------------
  assign lane0_status     = lane0_valid_i ? lane0_i.status : '0;
  assign lane1_status     = lane1_valid_i ? lane1_i.status : '0; // Idle lane adds nothing
  assign collapsed_status = lane0_status | lane1_status;

  assign resp_o = '{
    result: packed_result,
    status: collapsed_status,
    tag:    lane0_i.tag
  };

endmodule

/* hdl/fpnc_slice_top.sv */
`timescale 1ns/1ps

module fpnc_slice_top #(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // Request side
  input  fpnc_pkg::slice_req_t  in_req_i,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  // Response side
  output fpnc_pkg::slice_resp_t out_resp_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  // Items in flight
  output logic                  busy_o
);

  fpnc_pkg::lane0_in_t  lane0_in;
  fpnc_pkg::lane_in_t   lane1_in;
  logic                 lane0_in_valid, lane1_in_valid;
  fpnc_pkg::lane0_out_t lane0_out;
  fpnc_pkg::lane_out_t  lane1_out;
  logic                 lane0_out_valid, lane1_out_valid;
  logic                 lane1_used, lane1_out_ready, lane1_pack_valid;
  logic [1:0]           lane_busy;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  fpnc_operand_split i_operand_split (
    .req_i         ( in_req_i       ),
    .valid_i       ( in_valid_i     ),
    .lane0_o       ( lane0_in       ),
    .lane0_valid_o ( lane0_in_valid ),
    .lane1_o       ( lane1_in       ),
    .lane1_valid_o ( lane1_in_valid )
  );

  // --------------------------------------------------------------------------
  // Lanes
  // --------------------------------------------------------------------------
  fpnc_noncomp_lane #(
    .NumPipeRegs ( NumPipeRegs             ),
    .InType      ( fpnc_pkg::lane0_in_t    ),
    .OutType     ( fpnc_pkg::lane0_out_t   ),
    .LaneWidth   ( fpnc_pkg::SLICE_WIDTH   )
  ) i_lane0 (
    .clk_i,
    .arst_n_i,
    .in_i        ( lane0_in        ),
    .in_valid_i  ( lane0_in_valid  ),
    .in_ready_o  ( in_ready_o      ), // Upstream ready comes from lane 0
    .out_o       ( lane0_out       ),
    .out_valid_o ( lane0_out_valid ),
    .out_ready_i ( out_ready_i     ),
    .busy_o      ( lane_busy[0]    )
  );

  // Lane 1 retires only together with a vector result in lane 0
  assign lane1_used       = lane0_out_valid & lane0_out.aux.vectorial;
  assign lane1_out_ready  = out_ready_i & lane1_used;
  assign lane1_pack_valid = lane1_out_valid & lane1_used;

  fpnc_noncomp_lane #(
    .NumPipeRegs ( NumPipeRegs          ),
    .InType      ( fpnc_pkg::lane_in_t  ),
    .OutType     ( fpnc_pkg::lane_out_t ),
    .LaneWidth   ( fpnc_pkg::LANE_WIDTH )
  ) i_lane1 (
    .clk_i,
    .arst_n_i,
    .in_i        ( lane1_in        ),
    .in_valid_i  ( lane1_in_valid  ),
    .in_ready_o  (                 ), // Tracks lane 0
    .out_o       ( lane1_out       ),
    .out_valid_o ( lane1_out_valid ),
    .out_ready_i ( lane1_out_ready ),
    .busy_o      ( lane_busy[1]    )
  );

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------
  fpnc_result_pack i_result_pack (
    .lane0_i       ( lane0_out        ),
    .lane0_valid_i ( lane0_out_valid  ),
    .lane1_i       ( lane1_out        ),
    .lane1_valid_i ( lane1_pack_valid ),
    .resp_o        ( out_resp_o       )
  );

  assign out_valid_o = lane0_out_valid;
  assign busy_o      = |lane_busy;

endmodule

/* test/fpnc_slice_sva.sv */
`timescale 1ns/1ps

module fpnc_slice_sva (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input fpnc_pkg::slice_req_t  in_req_i,
  input logic                  in_valid_i,
  input logic                  in_ready_o,
  input fpnc_pkg::slice_resp_t out_resp_o,
  input logic                  out_valid_o,
  input logic                  out_ready_i,
  input logic                  busy_o
);

  // Stalled response stays put until taken
  out_hold_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_resp_o))
    else $error("stalled response changed");

  // Same rule upstream
  in_hold_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_req_i))
    else $error("stalled request changed");

  out_reset_a : assert property (@(posedge clk_i)
    !arst_n_i |-> !out_valid_o)
    else $error("response valid during reset");

  busy_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o |-> busy_o)
    else $error("response valid while not busy");

  // The slice only goes idle when its last response leaves
  busy_drop_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(busy_o) |-> $past(out_valid_o && out_ready_i))
    else $error("busy dropped without a response leaving");

endmodule

bind fpnc_slice_top fpnc_slice_sva i_fpnc_slice_sva (
  .clk_i       ( clk_i       ),
  .arst_n_i    ( arst_n_i    ),
  .in_req_i    ( in_req_i    ),
  .in_valid_i  ( in_valid_i  ),
  .in_ready_o  ( in_ready_o  ),
  .out_resp_o  ( out_resp_o  ),
  .out_valid_o ( out_valid_o ),
  .out_ready_i ( out_ready_i ),
  .busy_o      ( busy_o      )
);

/* test/fpnc_slice_tb.sv */
`timescale 1ns/1ps

module fpnc_slice_tb;

  localparam int unsigned NUM_PIPE_REGS = 2;
  localparam int unsigned NUM_REQ       = 400;
  localparam realtime     CLK_PERIOD    = 100ns;

  logic                  clk_i = 1'b0;
  logic                  arst_n_i;
  fpnc_pkg::slice_req_t  in_req_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  fpnc_pkg::slice_resp_t out_resp_o;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  busy_o;

  logic [31:0]           lcg_state = 32'h51eb8f39;
  fpnc_pkg::slice_resp_t exp_q [$];
  fpnc_pkg::slice_req_t  dir_q [$];
  int unsigned           n_issued  = 0;
  int unsigned           n_checked = 0;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  fpnc_slice_top #(
    .NumPipeRegs ( NUM_PIPE_REGS )
  ) fpnc_slice_top_i (
    .clk_i, .arst_n_i, .in_req_i, .in_valid_i, .in_ready_o,
    .out_resp_o, .out_valid_o, .out_ready_i, .busy_o
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ----------------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------------
  function automatic logic [31:0] ref_lane(input logic [31:0] a, input logic [31:0] b,
                                           input bit is32, input fpnc_pkg::operation_e op,
                                           input fpnc_pkg::roundmode_e rm, output logic nv);
    logic [7:0]  ea, eb, emax;
    logic [22:0] ma, mb;
    logic [30:0] mag_a, mag_b;
    logic        sa, sb, s, nan_a, nan_b, q_a, q_b, a_lt;
    logic [31:0] res;
    sa    = is32 ? a[31] : a[15];
    sb    = is32 ? b[31] : b[15];
    ea    = is32 ? a[30:23] : {3'b0, a[14:10]};
    eb    = is32 ? b[30:23] : {3'b0, b[14:10]};
    ma    = is32 ? a[22:0] : {13'b0, a[9:0]};
    mb    = is32 ? b[22:0] : {13'b0, b[9:0]};
    q_a   = is32 ? a[22] : a[9]; // Quiet bit
    q_b   = is32 ? b[22] : b[9];
    emax  = is32 ? 8'hff : 8'h1f;
    mag_a = is32 ? a[30:0] : {16'b0, a[14:0]};
    mag_b = is32 ? b[30:0] : {16'b0, b[14:0]};
    nan_a = (ea == emax) && (ma != 0);
    nan_b = (eb == emax) && (mb != 0);
    nv    = 1'b0;
    if (op == fpnc_pkg::SGNJ) begin
      case (rm)
        fpnc_pkg::RTZ: s = ~sb;
        fpnc_pkg::RDN: s = sa ^ sb;
        default:       s = sb;
      endcase
      res = is32 ? {s, a[30:0]} : {16'b0, s, a[14:0]};
    end else begin
      nv = (nan_a && !q_a) || (nan_b && !q_b);
      if (sa != sb) a_lt = sa; // -0 below +0
      else a_lt = sa ? (mag_a > mag_b) : (mag_a < mag_b);
      if (nan_a && nan_b) res = is32 ? 32'h7fc00000 : 32'h00007e00;
      else if (nan_a) res = b;
      else if (nan_b) res = a;
      else if (rm == fpnc_pkg::RTZ) res = a_lt ? b : a;
      else res = a_lt ? a : b;
      if (!is32) res = {16'b0, res[15:0]};
    end
    return res;
  endfunction

  function automatic fpnc_pkg::slice_resp_t ref_slice(input fpnc_pkg::slice_req_t req);
    fpnc_pkg::slice_resp_t resp;
    logic [31:0]           lo, hi;
    logic                  nv0, nv1;
    resp = '0;
    nv1  = 1'b0;
    hi   = 32'h0000ffff; // NaN-box for scalar FP16
    if (req.fmt == fpnc_pkg::FP32) begin
      lo = ref_lane(req.operands[0], req.operands[1], 1'b1, req.op, req.rnd_mode, nv0);
      resp.result = lo;
    end else begin
      lo = ref_lane({16'b0, req.operands[0][15:0]}, {16'b0, req.operands[1][15:0]},
                    1'b0, req.op, req.rnd_mode, nv0);
      if (req.vectorial) begin
        hi = ref_lane({16'b0, req.operands[0][31:16]}, {16'b0, req.operands[1][31:16]},
                      1'b0, req.op, req.rnd_mode, nv1);
      end
      resp.result = {hi[15:0], lo[15:0]};
    end
    resp.status.nv = nv0 | nv1;
    resp.tag       = req.tag;
    return resp;
  endfunction

  // ----------------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------------
  function automatic logic [15:0] pick16(input logic [31:0] r);
    case (r[31:29])
      3'd0:    return 16'h0000;
      3'd1:    return 16'h8000;
      3'd2:    return {r[0], 5'h1f, 1'b1, r[9:1]};        // Quiet NaN
      3'd3:    return {r[0], 5'h1f, 1'b0, r[9:1] | 9'h1}; // Signaling NaN
      3'd4:    return {r[0], 5'h1f, 10'h0};
      default: return r[15:0];
    endcase
  endfunction

  function automatic logic [31:0] pick32(input logic [31:0] r);
    case (r[31:29])
      3'd0:    return 32'h00000000;
      3'd1:    return 32'h80000000;
      3'd2:    return {r[0], 8'hff, 1'b1, r[22:1]};
      3'd3:    return {r[0], 8'hff, 1'b0, r[22:1] | 22'h1};
      3'd4:    return {r[0], 8'hff, 23'h0};
      default: return r;
    endcase
  endfunction

  function automatic fpnc_pkg::slice_req_t build_req(input fpnc_pkg::operation_e op,
      input fpnc_pkg::roundmode_e rm, input fpnc_pkg::fp_format_e fmt, input logic vec,
      input logic [31:0] a, input logic [31:0] b);
    fpnc_pkg::slice_req_t req;
    req             = '0;
    req.op          = op;
    req.rnd_mode    = rm;
    req.fmt         = fmt;
    req.vectorial   = vec;
    req.operands[0] = a;
    req.operands[1] = b;
    return req;
  endfunction

  function automatic fpnc_pkg::slice_req_t random_req();
    fpnc_pkg::slice_req_t req;
    logic [31:0]          r;
    logic [1:0][31:0]     ops;
    r   = lcg_next();
    req = '0;
    req.op  = r[0] ? fpnc_pkg::MINMAX : fpnc_pkg::SGNJ;
    req.fmt = r[1] ? fpnc_pkg::FP16 : fpnc_pkg::FP32;
    req.vectorial = (req.fmt == fpnc_pkg::FP16) && r[2]; // Vectors only in FP16
    if (req.op == fpnc_pkg::SGNJ) begin
      req.rnd_mode = (r[4:3] == 2'd0) ? fpnc_pkg::RNE :
                     (r[4:3] == 2'd1) ? fpnc_pkg::RTZ : fpnc_pkg::RDN;
    end else begin
      req.rnd_mode = r[3] ? fpnc_pkg::RTZ : fpnc_pkg::RNE;
    end
    for (int i = 0; i < 2; i++) begin
      if (req.fmt == fpnc_pkg::FP32) ops[i] = pick32(lcg_next());
      else ops[i] = {pick16(lcg_next()), pick16(lcg_next())};
    end
    req.operands = ops;
    return req;
  endfunction

  task automatic load_directed();
    // FP32 sign injection, all three variants
    dir_q.push_back(build_req(fpnc_pkg::SGNJ, fpnc_pkg::RNE, fpnc_pkg::FP32, 0,
                              32'h3f800000, 32'hc0000000));
    dir_q.push_back(build_req(fpnc_pkg::SGNJ, fpnc_pkg::RTZ, fpnc_pkg::FP32, 0,
                              32'h3f800000, 32'hc0000000));
    dir_q.push_back(build_req(fpnc_pkg::SGNJ, fpnc_pkg::RDN, fpnc_pkg::FP32, 0,
                              32'hbf800000, 32'hc0000000));
    dir_q.push_back(build_req(fpnc_pkg::SGNJ, fpnc_pkg::RTZ, fpnc_pkg::FP16, 1,
                              32'hbc003c00, 32'h0000c000));
    dir_q.push_back(build_req(fpnc_pkg::SGNJ, fpnc_pkg::RNE, fpnc_pkg::FP16, 0,
                              32'h12343c00, 32'h0000c000));
    // Signed zeros, one NaN, two NaNs, sNaN in the upper lane
    dir_q.push_back(build_req(fpnc_pkg::MINMAX, fpnc_pkg::RNE, fpnc_pkg::FP32, 0,
                              32'h00000000, 32'h80000000));
    dir_q.push_back(build_req(fpnc_pkg::MINMAX, fpnc_pkg::RTZ, fpnc_pkg::FP16, 1,
                              32'h80000000, 32'h00008000));
    dir_q.push_back(build_req(fpnc_pkg::MINMAX, fpnc_pkg::RNE, fpnc_pkg::FP32, 0,
                              32'h7fc00001, 32'h40400000));
    dir_q.push_back(build_req(fpnc_pkg::MINMAX, fpnc_pkg::RTZ, fpnc_pkg::FP16, 1,
                              32'h7e007e00, 32'h7c017e01));
    dir_q.push_back(build_req(fpnc_pkg::MINMAX, fpnc_pkg::RNE, fpnc_pkg::FP16, 1,
                              32'h7c013c00, 32'h40004000));
  endtask

  // ----------------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------------
  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, exp);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_result(input logic [fpnc_pkg::SLICE_WIDTH-1:0] got,
                              input logic [fpnc_pkg::SLICE_WIDTH-1:0] exp);
    if (got !== exp) report_mismatch("result", got, exp);
  endtask

  task automatic check_status(input fpnc_pkg::status_t got, input fpnc_pkg::status_t exp);
    if (got !== exp) report_mismatch("status", 32'(got), 32'(exp));
  endtask

  task automatic check_tag(input fpnc_pkg::tag_t got, input fpnc_pkg::tag_t exp);
    if (got !== exp) report_mismatch("tag", 32'(got), 32'(exp));
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) report_mismatch("busy", 32'(got), 32'(exp));
  endtask

  // Records each accepted request
  always @(posedge clk_i) begin
    if (arst_n_i && in_valid_i && in_ready_o) exp_q.push_back(ref_slice(in_req_i));
  end

  always @(posedge clk_i) begin : compare_resp
    fpnc_pkg::slice_resp_t exp;
    if (arst_n_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("A response came out with no request waiting for it");
        $display("Simulation finished: FAIL");
        $fatal(1);
      end
      exp = exp_q.pop_front();
      check_result(out_resp_o.result, exp.result);
      check_status(out_resp_o.status, exp.status);
      check_tag(out_resp_o.tag, exp.tag);
      n_checked <= n_checked + 1;
    end
  end

  // Items in flight are the accepted requests not yet answered
  always @(negedge clk_i) begin : compare_busy
    if (arst_n_i) check_busy(busy_o, exp_q.size() != 0);
  end

  initial begin : watchdog
    #(CLK_PERIOD * (NUM_REQ * 20 + 8 + 20));
    $display("Timeout, the run did not finish all requests in time");
    $display("Simulation finished: FAIL");
    $fatal(1);
  end

  // ----------------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------------
  initial begin : drive
    logic [31:0]          r;
    fpnc_pkg::slice_req_t req;
    arst_n_i    = 1'b0;
    in_req_i    = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    load_directed();
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0 || in_ready_o !== 1'b1) begin
      $display("Reset state is wrong, expected idle outputs and ready input");
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
    while (n_checked < NUM_REQ) begin
      @(posedge clk_i);
      r = lcg_next();
      if (!in_valid_i || in_ready_o) begin
        if (n_issued < NUM_REQ && r[1:0] != 2'd0) begin
          req     = (dir_q.size() != 0) ? dir_q.pop_front() : random_req();
          req.tag = n_issued[3:0];
          in_req_i   <= req;
          in_valid_i <= 1'b1;
          n_issued   = n_issued + 1;
        end else begin
          in_valid_i <= 1'b0;
        end
      end
      out_ready_i <= (r[4:2] != 3'd0); // Stall about one cycle in eight
    end
    @(posedge clk_i);
    if (exp_q.size() == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      $display("Requests were accepted but never answered");
      $display("Simulation finished: FAIL");
      $fatal(1);
    end
  end

endmodule

/* fpnc_slice.f */
hdl/fpnc_pkg.sv
hdl/fpnc_operand_split.sv
hdl/fpnc_pipe_reg.sv
hdl/fpnc_noncomp_lane.sv
hdl/fpnc_result_pack.sv
hdl/fpnc_slice_top.sv
test/fpnc_slice_sva.sv
test/fpnc_slice_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := fpnc_slice_tb
FILELIST  := fpnc_slice.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
